//--- ipf.f
hdl/ipf_geom_pkg.sv
hdl/ipf_filter_pkg.sv
hdl/lcu_scan_if.sv
hdl/band_offset.sv
hdl/pixel_filter.sv
hdl/lcu_walker.sv
hdl/ipf_top.sv
dv/ipf_checker.sv
dv/ipf_tb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f ipf.f --top-module ipf_tb -o ipf_sim
	out=$$(./obj_dir/ipf_sim); status=$$?; echo "$$out"; \
	test $$status -eq 0 && echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only --timing --assert -f ipf.f --top-module ipf_tb

clean:
	rm -rf obj_dir

//--- dv/ipf_tb.sv
module ipf_tb;

    localparam int FRAME_PIXELS = 128 * 128;
    localparam int TIMEOUT_CYCLES = 3 * 3 * FRAME_PIXELS + 1000;   // three frames

    logic clk, reset, in_en, busy, out_en, finish;
    ipf_geom_pkg::pixel_t        din, dout;
    ipf_geom_pkg::addr_t         dout_addr;
    ipf_filter_pkg::ipf_mode_e   ipf_type;
    ipf_filter_pkg::band_t       ipf_band_pos;
    ipf_filter_pkg::offset_set_t ipf_offset;
    ipf_geom_pkg::lcu_pos_t      lcu_x, lcu_y;
    ipf_geom_pkg::lcu_size_t     lcu_size;

    // expected outputs in emit order
    ipf_geom_pkg::pixel_t exp_pix_q[$];
    ipf_geom_pkg::addr_t  exp_addr_q[$];
    logic                 exp_last_q[$];

    // settings of the LCU being driven
    ipf_filter_pkg::ipf_mode_e blk_mode;
    logic [15:0]               blk_ofs;
    int                        blk_band, blk_x, blk_y, blk_size;

    logic [31:0] rng_state = 32'd10;
    int          cycles = 0;
    int          errors, test_errors, tests_run, tests_passed;
    logic        armed, busy_exp, finish_exp, drv_last_col;

    ipf_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'(rng_state[30:15]);   // low bits of an LCG are weak
    endfunction

    function automatic ipf_geom_pkg::pixel_t clip_add(int pix, logic [3:0] off);
        int sum;
        sum = pix + int'($signed(off));
        if (sum < 0)
            return 8'd0;
        if (sum > 255)
            return 8'd255;
        return ipf_geom_pkg::pixel_t'(sum);
    endfunction

    // offset 0 lives in the top nibble
    function automatic logic [3:0] pick_offset(logic [15:0] ofs, int idx);
        return ofs[15 - 4 * idx -: 4];
    endfunction

    function automatic ipf_geom_pkg::pixel_t band_model(int pix, int pos, logic [15:0] ofs);
        int band;
        band = pix / 8;
        if (band >= pos - 1 && band <= pos + 1)
            return ipf_geom_pkg::pixel_t'(pix);
        return clip_add(pix, pick_offset(ofs, band % 4));
    endfunction

    function automatic ipf_geom_pkg::pixel_t edge_model(int a, int c, int b, logic [15:0] ofs);
        if (c < a && c < b)
            return clip_add(c, pick_offset(ofs, 0));   // valley
        if (c > a && c > b)
            return clip_add(c, pick_offset(ofs, 3));   // peak
        if (2 * c < a + b)
            return clip_add(c, pick_offset(ofs, 1));
        if (2 * c > a + b)
            return clip_add(c, pick_offset(ofs, 2));
        return ipf_geom_pkg::pixel_t'(c);
    endfunction

    task automatic check_pixel(string name, ipf_geom_pkg::pixel_t got, ipf_geom_pkg::pixel_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_addr(string name, ipf_geom_pkg::addr_t got, ipf_geom_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycles);
            test_errors++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (armed && reset) begin
            check_flag("out_en", out_en, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_flag("finish", finish, 1'b0);
            busy_exp   = 1'b0;
            finish_exp = 1'b0;
        end else if (armed) begin
            check_flag("busy", busy, busy_exp);
            busy_exp = in_en && ipf_type == ipf_filter_pkg::IPF_EDGE && drv_last_col;
            if (out_en && exp_pix_q.size() == 0) begin
                $display("out_en pulsed with no pixel left to expect at cycle %0d", cycles);
                test_errors++;
            end else if (out_en) begin
                if (exp_last_q.pop_front())
                    finish_exp = 1'b1;
                check_pixel("dout", dout, exp_pix_q.pop_front());
                check_addr("dout_addr", dout_addr, exp_addr_q.pop_front());
            end
            check_flag("finish", finish, finish_exp);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d pixels never came out",
                     cycles, exp_pix_q.size());
            $display("tests failed");
            $finish;
        end
    end

    // waits out the flush cycle and random gaps
    task automatic drive_pixel(ipf_geom_pkg::pixel_t pix, logic last_col);
        do begin
            @(posedge clk);
            #1;
            in_en = 1'b0;
            drv_last_col = 1'b0;
        end while (busy || next_rand() % 4 == 0);
        in_en        = 1'b1;
        din          = pix;
        ipf_type     = blk_mode;
        ipf_offset   = ipf_filter_pkg::offset_set_t'(blk_ofs);
        ipf_band_pos = ipf_filter_pkg::band_t'(blk_band);
        lcu_x        = ipf_geom_pkg::lcu_pos_t'(blk_x);
        lcu_y        = ipf_geom_pkg::lcu_pos_t'(blk_y);
        lcu_size     = ipf_geom_pkg::lcu_size_t'(blk_size);
        drv_last_col = last_col;
    endtask

    task automatic run_lcu(int size, int lx, int ly);
        ipf_geom_pkg::pixel_t pix [4096];
        ipf_geom_pkg::pixel_t res;
        int side, last, k;
        side     = 16 << size;
        last     = 7 >> size;
        blk_mode = ipf_filter_pkg::ipf_mode_e'(2'(next_rand() % 3));
        blk_ofs  = 16'(next_rand());
        blk_band = next_rand() % 32;
        blk_x    = lx;
        blk_y    = ly;
        blk_size = size;
        for (int i = 0; i < side * side; i++)
            pix[i] = ipf_geom_pkg::pixel_t'(next_rand());
        for (int r = 0; r < side; r++) begin
            for (int cc = 0; cc < side; cc++) begin
                k = r * side + cc;
                if (blk_mode == ipf_filter_pkg::IPF_BAND)
                    res = band_model(int'(pix[k]), blk_band, blk_ofs);
                else if (blk_mode == ipf_filter_pkg::IPF_EDGE && cc != 0 && cc != side - 1)
                    res = edge_model(int'(pix[k - 1]), int'(pix[k]), int'(pix[k + 1]), blk_ofs);
                else
                    res = pix[k];   // off mode or LCU border
                exp_pix_q.push_back(res);
                exp_addr_q.push_back(ipf_geom_pkg::addr_t'((ly * side + r) * 128 + lx * side + cc));
                exp_last_q.push_back(lx == last && ly == last && k == side * side - 1);
            end
        end
        for (int i = 0; i < side * side; i++)
            drive_pixel(pix[i], (i % side) == side - 1);
    endtask

    task automatic run_frame(int size);
        int n;
        n = 8 >> size;
        test_errors = 0;
        @(posedge clk);
        #1;
        reset = 1'b1;
        armed = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int ly = 0; ly < n; ly++)
            for (int lx = 0; lx < n; lx++)
                run_lcu(size, lx, ly);
        @(posedge clk);
        #1;
        in_en = 1'b0;
        drv_last_col = 1'b0;
        while (exp_pix_q.size() != 0)
            @(posedge clk);
        @(negedge clk);
        #1;   // let the monitor finish this edge first
        check_flag("finish", finish, 1'b1);
        tests_run++;
        if (test_errors == 0)
            tests_passed++;
        errors += test_errors;
        $display("test %0d lcu_size %0d: %0d LCUs, %0d mismatches",
                 tests_run, size, n * n, test_errors);
    endtask

    initial begin
        reset        = 1'b0;
        in_en        = 1'b0;
        din          = '0;
        ipf_type     = ipf_filter_pkg::IPF_OFF;
        ipf_band_pos = '0;
        ipf_offset   = '0;
        lcu_x        = '0;
        lcu_y        = '0;
        lcu_size     = '0;
        armed        = 1'b0;
        busy_exp     = 1'b0;
        finish_exp   = 1'b0;
        drv_last_col = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;
        for (int s = 0; s < 3; s++)
            run_frame(s);
        $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- dv/ipf_checker.sv
module ipf_checker (
    input logic clk,
    input logic reset,
    input logic in_en,
    input logic busy,
    input logic out_en,
    input logic finish
);

    // input is not allowed during the flush cycle
    no_input_while_busy: assert property (
        @(posedge clk) disable iff (reset) !(in_en && busy)
    ) else $error("in_en high while busy");

    busy_single_cycle: assert property (
        @(posedge clk) disable iff (reset) busy |=> !busy
    ) else $error("busy high for two cycles in a row");

    finish_sticky: assert property (
        @(posedge clk) disable iff (reset) finish |=> finish
    ) else $error("finish dropped without reset");

    // outputs come out of reset quiet
    quiet_after_reset: assert property (
        @(posedge clk) reset |=> (!out_en && !busy && !finish)
    ) else $error("out_en, busy or finish high right after reset");

endmodule

bind ipf_top ipf_checker u_checker (
    .clk    (clk),
    .reset  (reset),
    .in_en  (in_en),
    .busy   (busy),
    .out_en (out_en),
    .finish (finish)
);

//--- hdl/ipf_top.sv
module ipf_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_en,
    input  ipf_geom_pkg::pixel_t         din,
    input  ipf_filter_pkg::ipf_mode_e    ipf_type,
    input  ipf_filter_pkg::band_t        ipf_band_pos,
    input  ipf_filter_pkg::offset_set_t  ipf_offset,
    input  ipf_geom_pkg::lcu_pos_t       lcu_x,
    input  ipf_geom_pkg::lcu_pos_t       lcu_y,
    input  ipf_geom_pkg::lcu_size_t      lcu_size,
    output logic                         busy,
    output logic                         out_en,
    output ipf_geom_pkg::pixel_t         dout,
    output ipf_geom_pkg::addr_t          dout_addr,
    output logic                         finish
);

    lcu_scan_if scan ();

    // pixel datapath, decides accept and emit
    pixel_filter u_filter (
        .clk          (clk),
        .reset        (reset),
        .in_en        (in_en),
        .din          (din),
        .ipf_type     (ipf_type),
        .ipf_band_pos (ipf_band_pos),
        .ipf_offset   (ipf_offset),
        .scan         (scan.filter),
        .busy         (busy),
        .out_en       (out_en),
        .dout         (dout)
    );

    // position tracking and addresses
    lcu_walker u_walker (
        .clk       (clk),
        .reset     (reset),
        .lcu_x     (lcu_x),
        .lcu_y     (lcu_y),
        .lcu_size  (lcu_size),
        .scan      (scan.walker),
        .dout_addr (dout_addr),
        .finish    (finish)
    );

endmodule

//--- hdl/lcu_walker.sv
module lcu_walker (
    input  logic                     clk,
    input  logic                     reset,
    input  ipf_geom_pkg::lcu_pos_t   lcu_x,
    input  ipf_geom_pkg::lcu_pos_t   lcu_y,
    input  ipf_geom_pkg::lcu_size_t  lcu_size,
    lcu_scan_if.walker               scan,
    output ipf_geom_pkg::addr_t      dout_addr,
    output logic                     finish
);

    localparam int BASE_LOG = $clog2(ipf_geom_pkg::LCU_BASE);

    typedef enum logic {
        SCAN_RUN,
        SCAN_DONE
    } scan_state_e;

    scan_state_e state_q;

    ipf_geom_pkg::lcu_pos_t  x_q, y_q, cur_x, cur_y;
    ipf_geom_pkg::lcu_size_t size_q, cur_size;
    ipf_geom_pkg::coord_t    in_col_q, out_row_q, out_col_q, last_idx;
    ipf_geom_pkg::addr_t     row_abs, col_abs;
    logic                    last_lcu, lcu_end;

    // a new LCU shows up on the live inputs before the latch catches it
    assign cur_x    = scan.accept ? lcu_x : x_q;
    assign cur_y    = scan.accept ? lcu_y : y_q;
    assign cur_size = scan.accept ? lcu_size : size_q;

    assign last_idx = (ipf_geom_pkg::coord_t'(ipf_geom_pkg::LCU_BASE) << cur_size) - 1'b1;

    assign scan.first_col = (in_col_q == '0);
    assign scan.last_col  = (in_col_q == last_idx);

    assign last_lcu =
        (cur_x == ipf_geom_pkg::lcu_pos_t'(ipf_geom_pkg::LCU_LAST_IDX >> cur_size)) &&
        (cur_y == ipf_geom_pkg::lcu_pos_t'(ipf_geom_pkg::LCU_LAST_IDX >> cur_size));
    assign lcu_end = (out_col_q == last_idx) && (out_row_q == last_idx);

    // absolute row and column in the frame, LCU origin by shifts
    assign row_abs = (ipf_geom_pkg::addr_t'(cur_y) << (BASE_LOG + cur_size))
                   + ipf_geom_pkg::addr_t'(out_row_q);
    assign col_abs = (ipf_geom_pkg::addr_t'(cur_x) << (BASE_LOG + cur_size))
                   + ipf_geom_pkg::addr_t'(out_col_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q   <= SCAN_RUN;
            x_q       <= '0;
            y_q       <= '0;
            size_q    <= '0;
            in_col_q  <= '0;
            out_row_q <= '0;
            out_col_q <= '0;
        end else begin
            if (scan.accept) begin
                x_q    <= lcu_x;
                y_q    <= lcu_y;
                size_q <= lcu_size;
                if (scan.last_col)
                    in_col_q <= '0;
                else
                    in_col_q <= in_col_q + 1'b1;
            end
            if (scan.emit) begin
                if (out_col_q == last_idx) begin
                    out_col_q <= '0;
                    if (out_row_q == last_idx)
                        out_row_q <= '0;   // next LCU
                    else
                        out_row_q <= out_row_q + 1'b1;
                end else begin
                    out_col_q <= out_col_q + 1'b1;
                end
                if (lcu_end && last_lcu)
                    state_q <= SCAN_DONE;  // sticky until reset
            end
        end
    end

    // address rides along with its pixel
    always_ff @(posedge clk) begin
        if (scan.emit)
            dout_addr <= (row_abs << ipf_geom_pkg::FRAME_W_LOG) + col_abs;
    end

    assign finish = (state_q == SCAN_DONE);

endmodule

//--- hdl/pixel_filter.sv
module pixel_filter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_en,
    input  ipf_geom_pkg::pixel_t         din,
    input  ipf_filter_pkg::ipf_mode_e    ipf_type,
    input  ipf_filter_pkg::band_t        ipf_band_pos,
    input  ipf_filter_pkg::offset_set_t  ipf_offset,
    lcu_scan_if.filter                   scan,
    output logic                         busy,
    output logic                         out_en,
    output ipf_geom_pkg::pixel_t         dout
);

    ipf_filter_pkg::ipf_mode_e   mode_q, cur_mode;
    ipf_filter_pkg::offset_set_t off_q, cur_off;
    ipf_filter_pkg::band_t       band_pos_q, cur_band_pos;
    ipf_filter_pkg::edge_cat_e   cat;

    ipf_geom_pkg::pixel_t left_q, centre_q, band_pix, edge_pix, next_dout;
    logic                 centre_first_q, flush_q, accept, emit, border;
    logic [8:0]           side_sum, centre_x2;
    logic signed [3:0]    edge_off;

    assign accept = in_en;   // never driven while busy

    // live settings on accept, latched ones during the flush
    assign cur_mode     = accept ? ipf_type : mode_q;
    assign cur_off      = accept ? ipf_offset : off_q;
    assign cur_band_pos = accept ? ipf_band_pos : band_pos_q;

    // edge mode holds the centre until its right neighbour arrives
    assign emit = (accept && (cur_mode != ipf_filter_pkg::IPF_EDGE || !scan.first_col))
               || flush_q;

    band_offset u_band (
        .pixel    (din),
        .band_pos (cur_band_pos),
        .offsets  (cur_off),
        .result   (band_pix)
    );

    always_comb begin
        side_sum  = {1'b0, left_q} + {1'b0, din};
        centre_x2 = {centre_q, 1'b0};
        border    = centre_first_q || flush_q;   // first or last column

        if (border)
            cat = ipf_filter_pkg::EDGE_FLAT;
        else if (centre_q < left_q && centre_q < din)
            cat = ipf_filter_pkg::EDGE_VALLEY;
        else if (centre_q > left_q && centre_q > din)
            cat = ipf_filter_pkg::EDGE_PEAK;
        else if (centre_x2 < side_sum)
            cat = ipf_filter_pkg::EDGE_CONCAVE;
        else if (centre_x2 > side_sum)
            cat = ipf_filter_pkg::EDGE_CONVEX;
        else
            cat = ipf_filter_pkg::EDGE_FLAT;

        case (cat)
            ipf_filter_pkg::EDGE_VALLEY:  edge_off = cur_off.off0;
            ipf_filter_pkg::EDGE_CONCAVE: edge_off = cur_off.off1;
            ipf_filter_pkg::EDGE_CONVEX:  edge_off = cur_off.off2;
            ipf_filter_pkg::EDGE_PEAK:    edge_off = cur_off.off3;
            default:                      edge_off = 4'sd0;
        endcase

        if (cat == ipf_filter_pkg::EDGE_FLAT)
            edge_pix = centre_q;
        else
            edge_pix = ipf_filter_pkg::sat_offset(centre_q, edge_off);

        case (cur_mode)
            ipf_filter_pkg::IPF_BAND: next_dout = band_pix;
            ipf_filter_pkg::IPF_EDGE: next_dout = edge_pix;
            default:                  next_dout = din;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode_q         <= ipf_filter_pkg::IPF_OFF;
            centre_first_q <= 1'b0;
            flush_q        <= 1'b0;
            out_en         <= 1'b0;
        end else begin
            out_en  <= emit;
            // one flush cycle after a last column in edge mode
            flush_q <= accept && cur_mode == ipf_filter_pkg::IPF_EDGE && scan.last_col;
            if (accept) begin
                mode_q <= ipf_type;
                if (ipf_type == ipf_filter_pkg::IPF_EDGE)
                    centre_first_q <= scan.first_col;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            off_q      <= ipf_offset;
            band_pos_q <= ipf_band_pos;
            if (ipf_type == ipf_filter_pkg::IPF_EDGE) begin
                left_q   <= centre_q;   // shift window
                centre_q <= din;
            end
        end
        if (emit)
            dout <= next_dout;
    end

    assign busy        = flush_q;
    assign scan.accept = accept;
    assign scan.emit   = emit;

endmodule

//--- hdl/band_offset.sv
module band_offset (
    input  ipf_geom_pkg::pixel_t         pixel,
    input  ipf_filter_pkg::band_t        band_pos,
    input  ipf_filter_pkg::offset_set_t  offsets,
    output ipf_geom_pkg::pixel_t         result
);

    ipf_filter_pkg::band_t band;
    logic                  near_pos;
    logic signed [3:0]     off;

    assign band = pixel[7:3];

    // within one band of band_pos, 6 bits so the ends do not wrap
    assign near_pos = ({1'b0, band} + 6'd1 >= {1'b0, band_pos}) &&
                      ({1'b0, band} <= {1'b0, band_pos} + 6'd1);

    always_comb begin
        case (band[1:0])   // band index mod 4
            2'd0:    off = offsets.off0;
            2'd1:    off = offsets.off1;
            2'd2:    off = offsets.off2;
            default: off = offsets.off3;
        endcase
    end

    assign result = near_pos ? pixel : ipf_filter_pkg::sat_offset(pixel, off);

endmodule

//--- hdl/lcu_scan_if.sv
interface lcu_scan_if;

    logic accept;      // input pixel taken this cycle
    logic emit;        // output pixel produced this cycle
    logic first_col;   // pixel now at the input is in column 0
    logic last_col;    // pixel now at the input is in the last column

    modport filter (
        output accept,
        output emit,
        input  first_col,
        input  last_col
    );

    modport walker (
        input  accept,
        input  emit,
        output first_col,
        output last_col
    );

endinterface

//--- hdl/ipf_filter_pkg.sv
package ipf_filter_pkg;

    // per-LCU filter mode, as driven on ipf_type
    typedef enum logic [1:0] {
        IPF_OFF  = 2'd0,
        IPF_BAND = 2'd1,
        IPF_EDGE = 2'd2
    } ipf_mode_e;

    // horizontal edge class of the centre pixel
    typedef enum logic [2:0] {
        EDGE_VALLEY,
        EDGE_CONCAVE,
        EDGE_CONVEX,
        EDGE_PEAK,
        EDGE_FLAT
    } edge_cat_e;

    // off0 sits in bits 15:12
    typedef struct packed {
        logic signed [3:0] off0;
        logic signed [3:0] off1;
        logic signed [3:0] off2;
        logic signed [3:0] off3;
    } offset_set_t;

    typedef logic [4:0] band_t;   // pixel[7:3]

    // pixel plus 4-bit signed offset, clipped to 0..255
    function automatic ipf_geom_pkg::pixel_t sat_offset(
        input ipf_geom_pkg::pixel_t pix,
        input logic signed [3:0] off
    );
        logic [9:0] sum;
        sum = {2'b00, pix} + {{6{off[3]}}, off};
        if (sum[9])
            return 8'd0;     // went below zero
        else if (sum[8])
            return 8'd255;   // overflow past 255
        else
            return sum[7:0];
    endfunction

endpackage

//--- hdl/ipf_geom_pkg.sv
package ipf_geom_pkg;

    // one luma sample
    typedef logic [7:0] pixel_t;

    // frame address, 128 x 128 samples
    typedef logic [13:0] addr_t;

    // row or column inside an LCU, up to 63
    typedef logic [6:0] coord_t;

    // LCU index along x or y
    typedef logic [2:0] lcu_pos_t;

    // 0 -> 16, 1 -> 32, 2 -> 64
    typedef logic [1:0] lcu_size_t;

    localparam int FRAME_W_LOG = 7;    // frame is 128 wide
    localparam int LCU_BASE = 16;      // side at size code 0
    localparam int LCU_LAST_IDX = 7;   // last LCU index at size code 0

endpackage
